/* filelist.f */
+incdir+source
source/dsm_pkg.sv
source/dsm_ctrl_if.sv
source/error_history.sv
source/dsm_sequencer.sv
source/dsm_datapath.sv
source/pulse_width_modulator.sv
source/dsm_pwm_top.sv
verif/dsm_pwm_sva.sv
verif/tb_dsm_pwm.sv

/* source/dsm_ctrl_if.sv */
`timescale 1ns/1ns

// per-cycle control word, sequencer -> datapath
// valid in every cycle where en is high, no handshake
interface dsm_ctrl_if;

	dsm_pkg::src1_sel_t src1_sel;     // acc or zero
	dsm_pkg::src2_sel_t src2_sel;     // input or error history
	logic               inv_src1;     // ones' complement of src1
	logic               inv_src2;     // ones' complement of src2
	dsm_pkg::shift_t    rshift_count; // arithmetic right shift of src2
	logic               shift_sreg;   // step the error history
	logic               rotate_sreg;  // feed history output back to its input
	logic               truncate_acc; // keep only the centred error
	logic               acc_write;    // update acc this cycle

	modport seq (
		output src1_sel, src2_sel, inv_src1, inv_src2, rshift_count,
		output shift_sreg, rotate_sreg, truncate_acc, acc_write
	);

	modport dp (
		input src1_sel, src2_sel, inv_src1, inv_src2, rshift_count,
		input shift_sreg, rotate_sreg, truncate_acc, acc_write
	);

endinterface

/* source/dsm_datapath.sv */
`timescale 1ns/1ns
`include "dsm_defines.svh"

module dsm_datapath (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    en,
	input  logic [`DSM_IN_BITS-1:0]  u,
	dsm_ctrl_if.dp                  ctrl,
	output logic [`DSM_OUT_BITS-1:0] y
);

	localparam int F     = `DSM_FRAC_BITS;
	localparam int ACC_W = $bits(dsm_pkg::acc_t);

	dsm_pkg::acc_t  acc;
	dsm_pkg::acc_t  next_acc_sum; // acc from the adder
	dsm_pkg::acc_t  next_acc;
	dsm_pkg::err_t  err_in;
	dsm_pkg::err_t  err_out;      // oldest stored error
	dsm_pkg::full_t src1;
	dsm_pkg::full_t src2_raw;
	dsm_pkg::full_t src2_shifted;
	dsm_pkg::full_t src2;
	dsm_pkg::full_t sum;
	logic           carry_in;

	// ------------------------------------------------------------
	// operands
	// ------------------------------------------------------------
	always_comb begin
		src1 = (ctrl.src1_sel == dsm_pkg::SRC1_ACC) ? dsm_pkg::full_t'(acc) : '0;
		if (ctrl.inv_src1)
			src1 = ~src1;

		if (ctrl.src2_sel == dsm_pkg::SRC2_INPUT)
			src2_raw = dsm_pkg::full_t'({1'b0, u}); // unsigned, so >>> acts as >>
		else
			src2_raw = dsm_pkg::full_t'(err_out) <<< `DSM_MAX_LEFT_SHIFT;
		src2_shifted = src2_raw >>> ctrl.rshift_count;
		src2 = ctrl.inv_src2 ? ~src2_shifted : src2_shifted;
	end

	// ------------------------------------------------------------
	// shared adder
	// ------------------------------------------------------------
	// +1 turns the ones' complement into a negation
	assign carry_in = ctrl.inv_src1 | ctrl.inv_src2;
	assign sum      = src1 + src2 + dsm_pkg::full_t'(carry_in);
	assign y        = sum[`DSM_IN_BITS -: `DSM_OUT_BITS]; // quantized output

	always_comb begin
		next_acc_sum = dsm_pkg::acc_t'(sum);
		// keep the fraction, flip bit F-1 into the sign
		// acts like rounding to nearest, error lands in [-2^(F-1), 2^(F-1))
		if (ctrl.truncate_acc)
			next_acc_sum = {{(ACC_W - F + 1){~sum[F-1]}}, sum[F-2:0]};
	end

	// plain shift reloads acc with the oldest error
	assign next_acc = (ctrl.shift_sreg && !ctrl.rotate_sreg) ?
		dsm_pkg::acc_t'(err_out) : next_acc_sum;

	always_ff @(posedge clk) begin
		if (reset)
			acc <= '0;
		else if (en && ctrl.acc_write)
			acc <= next_acc;
	end

	assign err_in = dsm_pkg::err_t'(acc); // acc holds the error after the output step

	error_history u_history (
		.clk     (clk),
		.reset   (reset),
		.en      (en),
		.shift   (ctrl.shift_sreg),
		.rotate  (ctrl.rotate_sreg),
		.err_in  (err_in),
		.err_out (err_out)
	);

endmodule

/* source/dsm_defines.svh */
`ifndef DSM_DEFINES_SVH
`define DSM_DEFINES_SVH

// datapath widths
`define DSM_IN_BITS        16 // input sample, unsigned
`define DSM_FRAC_BITS      11 // bits below the output word
`define DSM_OUT_BITS       6  // output word = pwm word
`define DSM_SREG_INT_BITS  2  // guard bits above a stored error
`define DSM_NUM_TAPS       4  // highest noise shaping order

// shift limits
`define DSM_MAX_LEFT_SHIFT 2  // error operand pre-shift, rshift by this = x1
`define DSM_SHIFT_BITS     4  // width of any shift count

// sequencer encodings
`define DSM_STEP_BITS      4
`define DSM_PHASE_OUTPUT   2'd0 // read input, produce output, store error
`define DSM_PHASE_CORR     2'd1 // build next correction in acc
`define DSM_STEP_OUTPUT    4'd0 // step inside the output phase
`define DSM_STEP_SHIFT     4'd1

// order codes, same numbering as the older modulator
`define DSM_ORDER_4        2'd0
`define DSM_ORDER_3        2'd1
`define DSM_ORDER_2        2'd2
`define DSM_ORDER_1        2'd3

`endif

/* source/dsm_pkg.sv */
`include "dsm_defines.svh"

package dsm_pkg;

	// ------------------------------------------------------------
	// word types
	// ------------------------------------------------------------
	typedef logic signed [`DSM_IN_BITS:0] full_t; // one bit over the input
	typedef logic signed [`DSM_FRAC_BITS+`DSM_SREG_INT_BITS-1:0] err_t;
	typedef logic signed [`DSM_FRAC_BITS+`DSM_SREG_INT_BITS+`DSM_NUM_TAPS-1:0] acc_t;
	typedef logic [`DSM_SHIFT_BITS-1:0] shift_t;

	// ------------------------------------------------------------
	// control codes
	// ------------------------------------------------------------
	typedef enum logic {
		SRC1_ACC,  // accumulator
		SRC1_ZERO  // start a fresh sum
	} src1_sel_t;

	typedef enum logic {
		SRC2_INPUT, // u, zero extended
		SRC2_ERR    // oldest entry of the error history
	} src2_sel_t;

	typedef logic [1:0] order_t; // see DSM_ORDER_* codes

	typedef enum logic [1:0] {
		PH_OUTPUT = `DSM_PHASE_OUTPUT,
		PH_CORR   = `DSM_PHASE_CORR
	} phase_t;

endpackage

/* source/dsm_pwm_top.sv */
`timescale 1ns/1ns
`include "dsm_defines.svh"

module dsm_pwm_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`DSM_IN_BITS-1:0]  u,           // taken when y_valid and pulse_done
	input  dsm_pkg::shift_t         u_rshift,
	input  dsm_pkg::order_t         order_sel,
	input  logic [`DSM_OUT_BITS-1:0] compare_max, // keep the period above one sample sequence
	output logic                    pwm_out,
	output logic                    pulse_done,
	output logic                    y_valid,
	output logic [`DSM_OUT_BITS-1:0] pulse_width_out
);

	logic                     en;
	logic [`DSM_OUT_BITS-1:0] y;
	logic [`DSM_OUT_BITS-1:0] pulse_width;

	dsm_ctrl_if ctrl_bus ();

	// ------------------------------------------------------------
	// back-pressure
	// ------------------------------------------------------------
	// run freely through shift and correction, park on the output step
	// until the pwm period ends
	assign en = !y_valid || pulse_done;

	always_ff @(posedge clk) begin
		if (reset)
			pulse_width <= '0;
		else if (pulse_done)
			pulse_width <= y; // width for the next period
	end

	assign pulse_width_out = pulse_width;

	dsm_sequencer u_sequencer (
		.clk       (clk),
		.reset     (reset),
		.en        (en),
		.order_sel (order_sel),
		.u_rshift  (u_rshift),
		.y_valid   (y_valid),
		.ctrl      (ctrl_bus.seq)
	);

	dsm_datapath u_datapath (
		.clk   (clk),
		.reset (reset),
		.en    (en),
		.u     (u),
		.ctrl  (ctrl_bus.dp),
		.y     (y)
	);

	pulse_width_modulator u_pwm (
		.clk         (clk),
		.reset       (reset),
		.compare_max (compare_max),
		.pulse_width (pulse_width),
		.pwm_out     (pwm_out),
		.pulse_done  (pulse_done)
	);

endmodule

/* source/dsm_sequencer.sv */
`timescale 1ns/1ns
`include "dsm_defines.svh"

module dsm_sequencer (
	input  logic              clk,
	input  logic              reset,
	input  logic              en,
	input  dsm_pkg::order_t   order_sel, // change only while waiting at the output step
	input  dsm_pkg::shift_t   u_rshift,
	output logic              y_valid,
	dsm_ctrl_if.seq           ctrl
);

	// error operand is pre-shifted left, so these right shifts give the gain
	localparam dsm_pkg::shift_t SH_X4 = dsm_pkg::shift_t'(`DSM_MAX_LEFT_SHIFT - 2);
	localparam dsm_pkg::shift_t SH_X2 = dsm_pkg::shift_t'(`DSM_MAX_LEFT_SHIFT - 1);
	localparam dsm_pkg::shift_t SH_X1 = dsm_pkg::shift_t'(`DSM_MAX_LEFT_SHIFT);

	dsm_pkg::phase_t          phase, next_phase;
	logic [`DSM_STEP_BITS-1:0] step, next_step;
	logic                     last_step; // final correction, go back to output

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= dsm_pkg::PH_OUTPUT;
			step  <= `DSM_STEP_OUTPUT; // y_valid high right after reset
		end else if (en) begin
			phase <= next_phase;
			step  <= next_step;
		end
	end

	// ------------------------------------------------------------
	// state decode
	// ------------------------------------------------------------
	// every order rotates the history three times in total,
	// so it is back in place when the next sample starts
	always_comb begin
		ctrl.src1_sel     = dsm_pkg::SRC1_ACC; // default acc += err
		ctrl.src2_sel     = dsm_pkg::SRC2_ERR;
		ctrl.inv_src1     = 1'b0;
		ctrl.inv_src2     = 1'b0;
		ctrl.rshift_count = SH_X1;
		ctrl.shift_sreg   = 1'b0;
		ctrl.rotate_sreg  = 1'b1;
		ctrl.truncate_acc = 1'b0;
		ctrl.acc_write    = 1'b1;
		y_valid           = 1'b0;
		last_step         = 1'b0;
		next_phase        = phase;
		next_step         = step + 1'b1;

		case (phase)
			dsm_pkg::PH_OUTPUT: begin
				if (step == `DSM_STEP_OUTPUT) begin
					// y = top of acc + x, acc keeps the error
					ctrl.src2_sel     = dsm_pkg::SRC2_INPUT;
					ctrl.rshift_count = u_rshift; // only place the input shift applies
					ctrl.truncate_acc = 1'b1;
					y_valid           = 1'b1;
				end else begin
					// error into history, oldest error back into acc
					ctrl.shift_sreg  = 1'b1;
					ctrl.rotate_sreg = 1'b0;
					next_phase       = dsm_pkg::PH_CORR;
					next_step        = '0;
				end
			end

			dsm_pkg::PH_CORR: begin
				case (order_sel)
					`DSM_ORDER_4: case (step) // acc holds e[n-3] on entry
						0: begin
							ctrl.inv_src1     = 1'b1; // 4 e[n-2] - e[n-3]
							ctrl.rshift_count = SH_X4;
							ctrl.shift_sreg   = 1'b1;
						end
						1: begin
							ctrl.inv_src2     = 1'b1; // -6 e[n-1] as -4 then -2
							ctrl.rshift_count = SH_X4;
						end
						2: begin
							ctrl.inv_src2     = 1'b1;
							ctrl.rshift_count = SH_X2;
							ctrl.shift_sreg   = 1'b1;
						end
						default: begin
							ctrl.rshift_count = SH_X4; // +4 e[n]
							ctrl.shift_sreg   = 1'b1;
							last_step         = 1'b1;
						end
					endcase

					`DSM_ORDER_3: case (step)
						0: begin
							ctrl.src1_sel   = dsm_pkg::SRC1_ZERO; // acc = e[n-2]
							ctrl.shift_sreg = 1'b1;
						end
						1: begin
							ctrl.inv_src2     = 1'b1; // -3 e[n-1] as -2 then -1
							ctrl.rshift_count = SH_X2;
						end
						2: begin
							ctrl.inv_src2   = 1'b1;
							ctrl.shift_sreg = 1'b1;
						end
						3: ctrl.rshift_count = SH_X2; // +3 e[n] as +2 then +1
						default: begin
							ctrl.shift_sreg = 1'b1;
							last_step       = 1'b1;
						end
					endcase

					`DSM_ORDER_2: case (step)
						0: begin
							ctrl.acc_write  = 1'b0; // skip e[n-2]
							ctrl.shift_sreg = 1'b1;
						end
						1: begin
							ctrl.src1_sel   = dsm_pkg::SRC1_ZERO; // acc = -e[n-1]
							ctrl.inv_src2   = 1'b1;
							ctrl.shift_sreg = 1'b1;
						end
						default: begin
							ctrl.rshift_count = SH_X2; // +2 e[n]
							ctrl.shift_sreg   = 1'b1;
							last_step         = 1'b1;
						end
					endcase

					default: case (step) // first order
						0, 1: begin
							ctrl.acc_write  = 1'b0; // skip e[n-2], e[n-1]
							ctrl.shift_sreg = 1'b1;
						end
						default: begin
							ctrl.src1_sel   = dsm_pkg::SRC1_ZERO; // acc = e[n]
							ctrl.shift_sreg = 1'b1;
							last_step       = 1'b1;
						end
					endcase
				endcase
			end

			default: begin
				ctrl.acc_write = 1'b0; // unused code, recover
				last_step      = 1'b1;
			end
		endcase

		if (last_step) begin
			next_phase = dsm_pkg::PH_OUTPUT;
			next_step  = `DSM_STEP_OUTPUT;
		end
	end

endmodule

/* source/error_history.sv */
`timescale 1ns/1ns
`include "dsm_defines.svh"

// past quantization errors, newest in slot 0
module error_history (
	input  logic          clk,
	input  logic          reset,
	input  logic          en,
	input  logic          shift,
	input  logic          rotate, // recirculate instead of taking err_in
	input  dsm_pkg::err_t err_in,
	output dsm_pkg::err_t err_out
);

	localparam int DEPTH = `DSM_NUM_TAPS - 1; // acc holds the oldest tap

	dsm_pkg::err_t hist [DEPTH];
	dsm_pkg::err_t head; // next value of slot 0

	assign head    = rotate ? hist[DEPTH-1] : err_in;
	assign err_out = hist[DEPTH-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++)
				hist[i] <= '0; // errors before the first sample count as zero
		end else if (en && shift) begin
			hist[0] <= head;
			for (int i = 1; i < DEPTH; i++)
				hist[i] <= hist[i-1];
		end
	end

endmodule

/* source/pulse_width_modulator.sv */
`timescale 1ns/1ns
`include "dsm_defines.svh"

// single slope pwm, period is compare_max+1 cycles
module pulse_width_modulator (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`DSM_OUT_BITS-1:0] compare_max,
	input  logic [`DSM_OUT_BITS-1:0] pulse_width,
	output logic                    pwm_out,
	output logic                    pulse_done
);

	logic [`DSM_OUT_BITS-1:0] count;
	logic                     period_end;

	// >= also pulls the counter back if compare_max drops below it
	assign period_end = (count >= compare_max);

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else if (period_end)
			count <= '0; // wrap
		else
			count <= count + 1'b1;
	end

	assign pulse_done = period_end;           // one cycle per period
	assign pwm_out    = (count < pulse_width); // high for pulse_width cycles

endmodule

/* verif/dsm_pwm_sva.sv */
`timescale 1ns/1ns
`include "dsm_defines.svh"

// timing rules of the sequencer park and the pwm strobe
module dsm_pwm_sva (
	input logic                     clk,
	input logic                     reset,
	input logic                     y_valid,
	input logic                     pulse_done,
	input logic [`DSM_OUT_BITS-1:0] pulse_width_out
);

	// parked on the output step, only the period end may release it
	park_hold: assert property (@(posedge clk) disable iff (reset)
		y_valid && !pulse_done |=> y_valid)
		else $error("sequencer left the output step before the period ended");

	done_width: assert property (@(posedge clk) disable iff (reset)
		pulse_done |=> !pulse_done) // compare_max is never 0 here
		else $error("pulse_done held for more than one cycle");

	// hold register loads on the period end only
	width_load: assert property (@(posedge clk) disable iff (reset)
		!$stable(pulse_width_out) |-> $past(pulse_done))
		else $error("pulse_width_out changed away from a period end");

endmodule

bind dsm_pwm_top dsm_pwm_sva sva_checks (
	.clk             (clk),
	.reset           (reset),
	.y_valid         (y_valid),
	.pulse_done      (pulse_done),
	.pulse_width_out (pulse_width_out)
);

/* verif/tb_dsm_pwm.sv */
`timescale 1ns/1ns
`include "dsm_defines.svh"

module tb_dsm_pwm;

	localparam int F             = `DSM_FRAC_BITS;
	localparam int OUT_MASK      = (1 << `DSM_OUT_BITS) - 1;
	localparam int CM_FIRST      = 20; // short period for the reset test
	localparam int CM_MAIN       = 31; // largest period used
	localparam int RESET_PERIODS = 4;
	localparam int ORDER_PERIODS = 16; // per order, constant u and random u
	localparam int SHIFT_PERIODS = 12; // per u_rshift value
	localparam int AVG_PERIODS   = 64;
	localparam int TOTAL_PERIODS = RESET_PERIODS + 8 * ORDER_PERIODS
		+ 4 * SHIFT_PERIODS + AVG_PERIODS + 1;
	localparam int TIMEOUT_NS    = (TOTAL_PERIODS + 20) * (CM_MAIN + 1) * 10;

	logic                     clk;
	logic                     reset;
	logic [`DSM_IN_BITS-1:0]  u;
	dsm_pkg::shift_t          u_rshift;
	dsm_pkg::order_t          order_sel;
	logic [`DSM_OUT_BITS-1:0] compare_max;
	logic                     pwm_out;
	logic                     pulse_done;
	logic                     y_valid;
	logic [`DSM_OUT_BITS-1:0] pulse_width_out;

	int checks = 0;
	int errors = 0;
	bit period_known = 1'b0; // first period after reset starts mid count
	int hist_e [4];          // model errors, newest first, zero at start
	int exp_width = 0;       // width the dut should hold in this period
	int last_width = 0;      // width seen at the last pulse_done

	dsm_pwm_top uut (
		.clk             (clk),
		.reset           (reset),
		.u               (u),
		.u_rshift        (u_rshift),
		.order_sel       (order_sel),
		.compare_max     (compare_max),
		.pwm_out         (pwm_out),
		.pulse_done      (pulse_done),
		.y_valid         (y_valid),
		.pulse_width_out (pulse_width_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns
	end

	// ------------------------------------------------------------
	// helpers and reference model
	// ------------------------------------------------------------
	task automatic check_value(input string name, input int got, input int expected);
		checks++;
		assert (got == expected) else begin
			$display("FAILED %s: got %h, expected %h", name, got, expected);
			errors++;
		end
	endtask

	function automatic int binom(input int n, input int k);
		int r;
		r = 1;
		for (int i = 1; i <= k; i++)
			r = r * (n - k + i) / i;
		return r;
	endfunction

	// cycles with y_valid low after a period end: shift step plus the corrections
	function automatic int busy_cycles(input dsm_pkg::order_t o);
		int r;
		case (o)
			`DSM_ORDER_4: r = 5;
			`DSM_ORDER_3: r = 6;
			default:      r = 4; // second and first order
		endcase
		return r;
	endfunction

	function automatic logic [`DSM_IN_BITS-1:0] rand_sample();
		logic [31:0] r;
		r = $urandom;
		return r[`DSM_IN_BITS-1:0];
	endfunction

	// one pwm period: wait for pulse_done, check it, step the model,
	// then drive the input for the following sample
	task automatic run_sample(input logic [`DSM_IN_BITS-1:0] next_u);
		int cycles;
		int highs;
		int lows;
		int n;
		int c;
		int v;
		cycles = 0;
		highs  = 0;
		lows   = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (pwm_out)
				highs++;
			if (!y_valid)
				lows++;
		end while (!pulse_done);

		if (period_known)
			check_value("pulse_done period", cycles, compare_max + 1);
		check_value("y_valid low cycles", lows, period_known ? busy_cycles(order_sel) : 0);
		check_value("pulse_width_out", pulse_width_out, exp_width);
		check_value("pwm_out high cycles", highs,
			(exp_width < compare_max + 1) ? exp_width : compare_max + 1);
		last_width = pulse_width_out;

		n = 4 - int'(order_sel); // code 0 is fourth order
		c = 0;
		for (int k = 1; k <= n; k++) // alternating binomial taps
			c += ((k % 2) ? 1 : -1) * binom(n, k) * hist_e[k-1];
		v = int'(u >> u_rshift) + c;
		exp_width = (v >>> F) & OUT_MASK;
		for (int k = 3; k > 0; k--)
			hist_e[k] = hist_e[k-1];
		hist_e[0] = (v & ((1 << F) - 1)) - (1 << (F - 1)); // centred error
		period_known = 1'b1;

		@(posedge clk);
		u <= next_u;
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic reset_and_period();
		@(negedge clk);
		check_value("pwm_out", pwm_out, 0);
		check_value("pulse_done", pulse_done, 0);
		check_value("pulse_width_out", pulse_width_out, 0);
		check_value("y_valid", y_valid, 1);
		repeat (RESET_PERIODS) run_sample(16'h8000);
	endtask

	// every order with a held level, then a new level each period
	task automatic order_sweep();
		logic [`DSM_IN_BITS-1:0] level;
		compare_max <= CM_MAIN;
		for (int o = 0; o < 4; o++) begin
			level = rand_sample();
			order_sel <= dsm_pkg::order_t'(o);
			u <= level;
			repeat (ORDER_PERIODS) run_sample(level);
			repeat (ORDER_PERIODS) run_sample(rand_sample());
		end
	endtask

	task automatic input_shift_sweep();
		order_sel <= `DSM_ORDER_2;
		for (int s = 0; s < 4; s++) begin
			u_rshift <= dsm_pkg::shift_t'(s);
			repeat (SHIFT_PERIODS) run_sample(rand_sample());
		end
		u_rshift <= '0;
	endtask

	// first order mean: y is floor(v / 2^F), so the sum telescopes to
	// (64 x + e_first - e_last - 64 * 2^(F-1)) / 2^F
	task automatic noise_shaped_average();
		logic [`DSM_IN_BITS-1:0] level;
		int sum;
		int diff;
		level = rand_sample() % 16'd57344 + 16'd4096; // keeps v inside one wrap
		order_sel <= `DSM_ORDER_1;
		u <= level;
		run_sample(level); // first sample with order 1 still in flight
		sum = 0;
		repeat (AVG_PERIODS) begin
			run_sample(level);
			sum += last_width;
		end
		diff = sum * (1 << F) - AVG_PERIODS * (int'(level) - (1 << (F - 1)));
		checks++;
		assert (diff <= (1 << F) && diff >= -(1 << F)) else begin
			$display("FAILED pulse_width_out sum: got %h, off by %h units of 2^-11",
				sum, diff);
			errors++;
		end
	endtask

	// ------------------------------------------------------------
	// run and watchdog
	// ------------------------------------------------------------
	initial begin
		void'($urandom(32'hee40));
		reset       = 1'b1;
		u           = '0;
		u_rshift    = '0;
		order_sel   = `DSM_ORDER_4;
		compare_max = CM_FIRST;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		reset_and_period();
		order_sweep();
		input_shift_sweep();
		noise_shaped_average();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before the tests finished");
		$display("checks %0d, errors %0d", checks, errors);
		$display("sim failed");
		$finish;
	end

endmodule
